// File: core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Width of data words and byte addresses.
`define DATA_W 32

// Size of the general purpose register file.
`define REG_N 32

// Bits needed to index one register.
`define REG_AW 5

// Address of the first instruction fetched after reset.
`define RESET_PC 32'h0000_0000

`endif

// File: isaPkg.sv
package isaPkg;

    // Primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // Function field values used under opSpecial.
    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } functT;

    typedef struct packed {
        opcodeT     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functT      funct;
    } rFmtT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFmtT;

    typedef struct packed {
        opcodeT      opcode;
        logic [25:0] target;
    } jFmtT;

    // One fetched word, seen through each of the three formats.
    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
        jFmtT jFmt;
    } instrWordT;

endpackage

// File: ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOpT;

    typedef enum logic [3:0] {
        sFetch,
        sDecode,
        sMemAddr,
        sMemRead,
        sMemWrite,
        sLoadBack,
        sExecute,
        sAluBack,
        sBranch,
        sJump
    } stateT;

    // Second ALU operand.
    typedef enum logic [1:0] {
        srcBReg   = 2'd0,
        srcBFour  = 2'd1,
        srcBImm   = 2'd2,
        srcBImmSh = 2'd3
    } srcBSelT;

    // Source of the next program counter.
    typedef enum logic [1:0] {
        pcAlu    = 2'd0,
        pcResult = 2'd1,
        pcJump   = 2'd2
    } pcSrcT;

endpackage

// File: ctrlIf.sv
`timescale 1ns/1ns

interface ctrlIf;

    logic              pcWrite;
    logic              pcCond;
    logic              instrOrData;
    logic              irWrite;
    logic              regDst;
    logic              memToReg;
    logic              regWrite;
    logic              link;
    logic              srcASel;
    ctrlPkg::srcBSelT  srcBSel;
    logic              zeroExt;
    ctrlPkg::aluOpT    aluOp;
    ctrlPkg::pcSrcT    pcSrc;

    // Status returned by the datapath.
    isaPkg::instrWordT instr;
    logic              zero;

    modport ctrl (
        output pcWrite, pcCond, instrOrData, irWrite, regDst, memToReg, regWrite, link,
        output srcASel, srcBSel, zeroExt, aluOp, pcSrc,
        input  instr, zero
    );

    modport dp (
        input  pcWrite, pcCond, instrOrData, irWrite, regDst, memToReg, regWrite, link,
        input  srcASel, srcBSel, zeroExt, aluOp, pcSrc,
        output instr, zero
    );

endinterface

// File: regFile.sv
`timescale 1ns/1ns
`include "core_params.svh"

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`REG_AW-1:0] raddrA,
    input  logic [`REG_AW-1:0] raddrB,
    input  logic [`REG_AW-1:0] waddr,
    input  logic               wen,
    input  logic [`DATA_W-1:0] wdata,
    output logic [`DATA_W-1:0] rdataA,
    output logic [`DATA_W-1:0] rdataB
);

    logic [`DATA_W-1:0] regs [`REG_N];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Register zero is hardwired.
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

// File: alu.sv
`timescale 1ns/1ns
`include "core_params.svh"

module alu (
    input  ctrlPkg::aluOpT     op,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    output logic [`DATA_W-1:0] y,
    output logic               zero
);

    localparam int HalfW = `DATA_W / 2;

    always_comb begin
        case (op)
            ctrlPkg::aluAdd: begin
                y = a + b;
            end
            ctrlPkg::aluSub: begin
                y = a - b;
            end
            ctrlPkg::aluAnd: begin
                y = a & b;
            end
            ctrlPkg::aluOr: begin
                y = a | b;
            end
            ctrlPkg::aluSlt: begin
                y = `DATA_W'($signed(a) < $signed(b));
            end
            ctrlPkg::aluLui: begin
                y = {b[HalfW-1:0], {HalfW{1'b0}}};
            end
            default: begin
                y = a + b;
            end
        endcase
    end

    // Used by beq after a subtract.
    assign zero = (y == '0);

endmodule

// File: controller.sv
`timescale 1ns/1ns

module controller (
    input  logic clk,
    input  logic rstN,
    ctrlIf.ctrl  cif,
    output logic memValid,
    output logic memWrite,
    input  logic memReady
);

    ctrlPkg::stateT state;
    ctrlPkg::stateT nextState;
    ctrlPkg::aluOpT execOp;
    isaPkg::opcodeT opcode;
    isaPkg::functT  funct;
    logic           xfer;
    logic           isRType;
    logic           isJal;

    assign opcode  = cif.instr.rFmt.opcode;
    assign funct   = cif.instr.rFmt.funct;
    assign isRType = (opcode == isaPkg::opSpecial);
    assign isJal   = (opcode == isaPkg::opJal);
    assign xfer    = memValid && memReady;

    ////////////////////////////////////////
    // State sequencing
    ////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            ctrlPkg::sFetch: begin
                if (xfer) begin
                    nextState = ctrlPkg::sDecode;
                end
            end
            ctrlPkg::sDecode: begin
                case (opcode)
                    isaPkg::opLw, isaPkg::opSw: begin
                        nextState = ctrlPkg::sMemAddr;
                    end
                    isaPkg::opSpecial, isaPkg::opAddiu, isaPkg::opOri, isaPkg::opLui: begin
                        nextState = ctrlPkg::sExecute;
                    end
                    isaPkg::opBeq: begin
                        nextState = ctrlPkg::sBranch;
                    end
                    isaPkg::opJ, isaPkg::opJal: begin
                        nextState = ctrlPkg::sJump;
                    end
                    default: begin
                        nextState = ctrlPkg::sFetch;
                    end
                endcase
            end
            ctrlPkg::sMemAddr: begin
                if (opcode == isaPkg::opLw) begin
                    nextState = ctrlPkg::sMemRead;
                end else begin
                    nextState = ctrlPkg::sMemWrite;
                end
            end
            ctrlPkg::sMemRead: begin
                if (xfer) begin
                    nextState = ctrlPkg::sLoadBack;
                end
            end
            ctrlPkg::sExecute: begin
                nextState = ctrlPkg::sAluBack;
            end
            default: begin
                if (state != ctrlPkg::sMemWrite || xfer) begin
                    nextState = ctrlPkg::sFetch;
                end
            end
        endcase
    end

    // The request lines are registered from the next state, so they are
    // already stable in the first cycle of each memory state.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= ctrlPkg::sFetch;
            memValid <= 1'b0;
            memWrite <= 1'b0;
        end else begin
            state    <= nextState;
            memValid <= nextState inside {ctrlPkg::sFetch, ctrlPkg::sMemRead, ctrlPkg::sMemWrite};
            memWrite <= (nextState == ctrlPkg::sMemWrite);
        end
    end

    ////////////////////////////////////////
    // Datapath controls
    ////////////////////////////////////////

    always_comb begin
        case (opcode)
            isaPkg::opOri: begin
                execOp = ctrlPkg::aluOr;
            end
            isaPkg::opLui: begin
                execOp = ctrlPkg::aluLui;
            end
            isaPkg::opSpecial: begin
                case (funct)
                    isaPkg::fnSubu: execOp = ctrlPkg::aluSub;
                    isaPkg::fnAnd:  execOp = ctrlPkg::aluAnd;
                    isaPkg::fnOr:   execOp = ctrlPkg::aluOr;
                    isaPkg::fnSlt:  execOp = ctrlPkg::aluSlt;
                    default:        execOp = ctrlPkg::aluAdd;
                endcase
            end
            default: begin
                execOp = ctrlPkg::aluAdd;
            end
        endcase
    end

    assign cif.zeroExt = (opcode == isaPkg::opOri);

    always_comb begin
        cif.pcWrite     = 1'b0;
        cif.pcCond      = 1'b0;
        cif.instrOrData = 1'b0;
        cif.irWrite     = 1'b0;
        cif.regDst      = 1'b0;
        cif.memToReg    = 1'b0;
        cif.regWrite    = 1'b0;
        cif.link        = 1'b0;
        cif.srcASel     = 1'b0;
        cif.srcBSel     = ctrlPkg::srcBReg;
        cif.aluOp       = ctrlPkg::aluAdd;
        cif.pcSrc       = ctrlPkg::pcAlu;
        case (state)
            ctrlPkg::sFetch: begin
                // PC plus four lands on the same edge as the instruction.
                cif.irWrite = xfer;
                cif.pcWrite = xfer;
                cif.srcBSel = ctrlPkg::srcBFour;
            end
            ctrlPkg::sDecode: begin
                cif.srcBSel = ctrlPkg::srcBImmSh;
            end
            ctrlPkg::sMemAddr, ctrlPkg::sMemRead, ctrlPkg::sMemWrite: begin
                cif.srcASel     = 1'b1;
                cif.srcBSel     = ctrlPkg::srcBImm;
                cif.instrOrData = (state != ctrlPkg::sMemAddr);
            end
            ctrlPkg::sLoadBack: begin
                cif.regWrite = 1'b1;
                cif.memToReg = 1'b1;
            end
            ctrlPkg::sExecute: begin
                cif.srcASel = 1'b1;
                cif.aluOp   = execOp;
                if (!isRType) begin
                    cif.srcBSel = ctrlPkg::srcBImm;
                end
            end
            ctrlPkg::sAluBack: begin
                cif.regWrite = 1'b1;
                cif.regDst   = isRType;
            end
            ctrlPkg::sBranch: begin
                cif.srcASel = 1'b1;
                cif.aluOp   = ctrlPkg::aluSub;
                cif.pcCond  = 1'b1;
                cif.pcSrc   = ctrlPkg::pcResult;
            end
            ctrlPkg::sJump: begin
                cif.pcWrite  = 1'b1;
                cif.pcSrc    = ctrlPkg::pcJump;
                cif.link     = isJal;
                cif.regWrite = isJal;
            end
            default: begin
                cif.pcSrc = ctrlPkg::pcAlu;
            end
        endcase
    end

endmodule

// File: datapath.sv
`timescale 1ns/1ns
`include "core_params.svh"

module datapath (
    input  logic               clk,
    input  logic               rstN,
    ctrlIf.dp                  cif,
    output logic [`DATA_W-1:0] memAddr,
    output logic [`DATA_W-1:0] memWData,
    input  logic [`DATA_W-1:0] memRData,
    input  logic               memReady
);

    isaPkg::instrWordT  ir;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] pcNext;
    logic [`DATA_W-1:0] mdr;
    logic [`DATA_W-1:0] regA;
    logic [`DATA_W-1:0] regB;
    logic [`DATA_W-1:0] result;
    logic [`DATA_W-1:0] rdA;
    logic [`DATA_W-1:0] rdB;
    logic [`DATA_W-1:0] srcA;
    logic [`DATA_W-1:0] srcB;
    logic [`DATA_W-1:0] aluY;
    logic [`DATA_W-1:0] imm;
    logic [`DATA_W-1:0] immSh;
    logic [`DATA_W-1:0] jumpTarget;
    logic [`DATA_W-1:0] wdata;
    logic [`REG_AW-1:0] waddr;
    logic               pcEn;
    logic               mdrLoad;

    ////////////////////////////////////////
    // Program counter and instruction
    ////////////////////////////////////////

    assign pcEn       = cif.pcWrite || (cif.pcCond && cif.zero);
    assign jumpTarget = {pc[`DATA_W-1:28], ir.jFmt.target, 2'b00};

    always_comb begin
        case (cif.pcSrc)
            ctrlPkg::pcResult: pcNext = result;
            ctrlPkg::pcJump:   pcNext = jumpTarget;
            default:           pcNext = aluY;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
            ir <= '0;
        end else begin
            if (pcEn) begin
                pc <= pcNext;
            end
            if (cif.irWrite) begin
                ir <= memRData;
            end
        end
    end

    assign cif.instr = ir;
    assign memAddr   = cif.instrOrData ? result : pc;
    assign memWData  = regB;

    ////////////////////////////////////////
    // Register file and operands
    ////////////////////////////////////////

    // jal always links into the last register.
    assign waddr = cif.link   ? `REG_AW'(`REG_N - 1) :
                   cif.regDst ? ir.rFmt.rd : ir.rFmt.rt;
    assign wdata = cif.link ? pc : (cif.memToReg ? mdr : result);

    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .raddrA (ir.rFmt.rs),
        .raddrB (ir.rFmt.rt),
        .waddr  (waddr),
        .wen    (cif.regWrite),
        .wdata  (wdata),
        .rdataA (rdA),
        .rdataB (rdB)
    );

    assign mdrLoad = cif.instrOrData && memReady;

    always_ff @(posedge clk) begin
        regA   <= rdA;
        regB   <= rdB;
        result <= aluY;
        if (mdrLoad) begin
            mdr <= memRData;
        end
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    assign imm   = cif.zeroExt ? {{(`DATA_W - 16){1'b0}}, ir.iFmt.imm} :
                                 {{(`DATA_W - 16){ir.iFmt.imm[15]}}, ir.iFmt.imm};
    assign immSh = {imm[`DATA_W-3:0], 2'b00};
    assign srcA  = cif.srcASel ? regA : pc;

    always_comb begin
        case (cif.srcBSel)
            ctrlPkg::srcBFour:  srcB = `DATA_W'(4);
            ctrlPkg::srcBImm:   srcB = imm;
            ctrlPkg::srcBImmSh: srcB = immSh;
            default:            srcB = regB;
        endcase
    end

    alu uAlu (
        .op   (cif.aluOp),
        .a    (srcA),
        .b    (srcB),
        .y    (aluY),
        .zero (cif.zero)
    );

endmodule

// File: mipsCore.sv
`timescale 1ns/1ns
`include "core_params.svh"

module mipsCore (
    input  logic               clk,
    input  logic               rstN,
    output logic               memValid,
    output logic               memWrite,
    output logic [`DATA_W-1:0] memAddr,
    output logic [`DATA_W-1:0] memWData,
    input  logic               memReady,
    input  logic [`DATA_W-1:0] memRData
);

    ctrlIf cif ();

    // Sequencing and request valid come from the controller.
    controller uController (
        .clk      (clk),
        .rstN     (rstN),
        .cif      (cif.ctrl),
        .memValid (memValid),
        .memWrite (memWrite),
        .memReady (memReady)
    );

    // Address and write data come from the datapath.
    datapath uDatapath (
        .clk      (clk),
        .rstN     (rstN),
        .cif      (cif.dp),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memRData (memRData),
        .memReady (memReady)
    );

endmodule

// File: mipsCore_sva.sv
`timescale 1ns/1ns
`include "core_params.svh"

module mipsCore_sva (
    input logic               clk,
    input logic               rstN,
    input logic               memValid,
    input logic               memWrite,
    input logic [`DATA_W-1:0] memAddr,
    input logic [`DATA_W-1:0] memWData,
    input logic               memReady
);

    int unsigned failCount = 0;

    // A stalled request keeps its address and direction, and a store keeps its data.
    holdWhileStalled: assert property (
        @(posedge clk) disable iff (!rstN)
        (memValid && !memReady) |=>
            (memValid && $stable(memWrite) && $stable(memAddr) &&
             (!memWrite || $stable(memWData)))
    ) else begin
        failCount++;
        $error("memory request changed while memReady was low");
    end

    quietInReset: assert property (
        @(posedge clk) !rstN |-> (!memValid && !memWrite)
    ) else begin
        failCount++;
        $error("memory request raised during reset");
    end

    wordAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        memValid |-> (memAddr[1:0] == 2'b00)
    ) else begin
        failCount++;
        $error("memory address is not word aligned");
    end

endmodule

bind mipsCore mipsCore_sva uSva (.*);

// File: tbClock.sv
`timescale 1ns/1ns

module tbClock #(
    parameter int PeriodNs    = 20,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2) clk = ~clk;
    end

    // Reset is released on a rising edge after ResetCycles edges.
    initial begin
        rstN <= 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// File: mipsCore_tb.sv
`timescale 1ns/1ns
`include "core_params.svh"

module mipsCore_tb;

    localparam int ProgLen       = 200;
    localparam int MemAw         = 11;
    localparam int MemWords      = 1 << MemAw;
    localparam int DataBase      = 'h1000;
    localparam int TimeoutCycles = ProgLen * 5 * 4 * 2;
    localparam logic [`DATA_W-1:0] LoopAddr = `DATA_W'(ProgLen * 4);

    logic               clk;
    logic               rstN;
    logic               memValid;
    logic               memWrite;
    logic [`DATA_W-1:0] memAddr;
    logic [`DATA_W-1:0] memWData;
    logic               memReady = 1'b0;
    logic [`DATA_W-1:0] memRData = '0;

    logic [`DATA_W-1:0] mem [MemWords];
    logic [31:0]        lfsrState = 32'd66067;
    logic [1:0]         waitLeft = 2'd0;
    logic               waitDrawn = 1'b0;
    int                 cycleCount = 0;

    // Instruction-set model state.
    logic [`DATA_W-1:0] modelRegs [`REG_N];
    logic [`DATA_W-1:0] modelPc;
    logic               expectData;
    logic               dataIsWrite;
    logic [`DATA_W-1:0] dataAddr;
    logic [`DATA_W-1:0] dataWData;
    logic [`REG_AW-1:0] loadDest;

    tbClock #(.PeriodNs(20), .ResetCycles(4)) uClock (.clk(clk), .rstN(rstN));

    mipsCore dut (
        .clk      (clk),
        .rstN     (rstN),
        .memValid (memValid),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memReady (memReady),
        .memRData (memRData)
    );

    ////////////////////////////////////////
    // Random source and program assembly
    ////////////////////////////////////////

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[31]};
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    // Registers 0 to 6 and 31, so values meet often and jal results get stored.
    function automatic logic [4:0] pickReg();
        logic [2:0] r;
        r = 3'(randBits(3));
        return (r == 3'd7) ? 5'd31 : {2'b00, r};
    endfunction

    function automatic isaPkg::functT pickFunct(input logic [2:0] sel);
        case (sel % 5)
            0: return isaPkg::fnAddu;
            1: return isaPkg::fnSubu;
            2: return isaPkg::fnAnd;
            3: return isaPkg::fnOr;
            default: return isaPkg::fnSlt;
        endcase
    endfunction

    function automatic isaPkg::instrWordT makeR(
        input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
        input isaPkg::functT fn
    );
        isaPkg::instrWordT w;
        w = '0;
        w.rFmt.opcode = isaPkg::opSpecial;
        w.rFmt.rs = rs;
        w.rFmt.rt = rt;
        w.rFmt.rd = rd;
        w.rFmt.funct = fn;
        return w;
    endfunction

    function automatic isaPkg::instrWordT makeI(
        input isaPkg::opcodeT op, input logic [4:0] rs, input logic [4:0] rt,
        input logic [15:0] imm
    );
        isaPkg::instrWordT w;
        w.iFmt.opcode = op;
        w.iFmt.rs = rs;
        w.iFmt.rt = rt;
        w.iFmt.imm = imm;
        return w;
    endfunction

    function automatic isaPkg::instrWordT makeJ(input isaPkg::opcodeT op, input int target);
        isaPkg::instrWordT w;
        w.jFmt.opcode = op;
        w.jFmt.target = 26'(target);
        return w;
    endfunction

    task automatic buildProgram();
        logic [3:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [2:0]  fsel;
        logic [15:0] dataOff;
        logic        eqRegs;
        int          target;
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = `DATA_W'(i * 4) ^ 32'h9E37_79B9;
        end
        for (int i = 0; i < ProgLen; i++) begin
            kind    = 4'(randBits(4));
            rs      = pickReg();
            rt      = pickReg();
            rd      = pickReg();
            imm     = 16'(randBits(16));
            fsel    = 3'(randBits(3));
            dataOff = 16'(DataBase + 4 * randBits(5));
            eqRegs  = 1'(randBits(1));
            // Control transfers only go forward, at most to the final loop.
            target  = i + 1 + int'(randBits(3));
            if (target > ProgLen) begin
                target = ProgLen;
            end
            case (kind)
                0, 1, 2: mem[i] = makeR(rs, rt, rd, pickFunct(fsel));
                3, 4:    mem[i] = makeI(isaPkg::opAddiu, rs, rt, imm);
                5:       mem[i] = makeI(isaPkg::opOri, rs, rt, imm);
                6:       mem[i] = makeI(isaPkg::opLui, 5'd0, rt, imm);
                7, 8:    mem[i] = makeI(isaPkg::opLw, 5'd0, rt, dataOff);
                9, 10, 11: mem[i] = makeI(isaPkg::opSw, 5'd0, rt, dataOff);
                12, 13: mem[i] = makeI(isaPkg::opBeq, rs, eqRegs ? rs : rt, 16'(target - i - 1));
                14:      mem[i] = makeJ(isaPkg::opJ, target);
                default: mem[i] = makeJ(isaPkg::opJal, target);
            endcase
        end
        mem[ProgLen] = makeJ(isaPkg::opJ, ProgLen);
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic abortRun();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic checkAddr(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t: memAddr got 0x%08h, expected 0x%08h", $time, got, exp);
            abortRun();
        end
    endtask

    task automatic checkWriteFlag(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t: memWrite got %b, expected %b", $time, got, exp);
            abortRun();
        end
    endtask

    task automatic checkWData(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t: memWData got 0x%08h, expected 0x%08h", $time, got, exp);
            abortRun();
        end
    endtask

    ////////////////////////////////////////
    // Instruction-set model
    ////////////////////////////////////////

    function automatic logic [`DATA_W-1:0] signExt(input logic [15:0] imm);
        return {{(`DATA_W - 16){imm[15]}}, imm};
    endfunction

    function automatic logic [`DATA_W-1:0] rTypeResult(
        input isaPkg::functT fn, input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b
    );
        case (fn)
            isaPkg::fnAddu: return a + b;
            isaPkg::fnSubu: return a - b;
            isaPkg::fnAnd:  return a & b;
            isaPkg::fnOr:   return a | b;
            default:        return ($signed(a) < $signed(b)) ? `DATA_W'(1) : `DATA_W'(0);
        endcase
    endfunction

    function automatic int wordIndex(input logic [`DATA_W-1:0] addr);
        return int'(addr[MemAw+1:2]);
    endfunction

    task automatic writeReg(input logic [`REG_AW-1:0] idx, input logic [`DATA_W-1:0] value);
        if (idx != '0) begin
            modelRegs[idx] = value;
        end
    endtask

    task automatic executeModel(input isaPkg::instrWordT w);
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] nextPc;
        a = modelRegs[w.rFmt.rs];
        b = modelRegs[w.rFmt.rt];
        nextPc = modelPc + 4;
        case (w.rFmt.opcode)
            isaPkg::opSpecial: writeReg(w.rFmt.rd, rTypeResult(w.rFmt.funct, a, b));
            isaPkg::opAddiu: writeReg(w.iFmt.rt, a + signExt(w.iFmt.imm));
            isaPkg::opOri: writeReg(w.iFmt.rt, a | {16'h0000, w.iFmt.imm});
            isaPkg::opLui: writeReg(w.iFmt.rt, {w.iFmt.imm, 16'h0000});
            isaPkg::opLw, isaPkg::opSw: begin
                expectData  = 1'b1;
                dataIsWrite = (w.iFmt.opcode == isaPkg::opSw);
                dataAddr    = a + signExt(w.iFmt.imm);
                dataWData   = b;
                loadDest    = w.iFmt.rt;
            end
            isaPkg::opBeq: begin
                if (a == b) begin
                    nextPc = nextPc + (signExt(w.iFmt.imm) << 2);
                end
            end
            isaPkg::opJ: nextPc = {nextPc[`DATA_W-1:28], w.jFmt.target, 2'b00};
            isaPkg::opJal: begin
                writeReg(`REG_AW'(31), nextPc);
                nextPc = {nextPc[`DATA_W-1:28], w.jFmt.target, 2'b00};
            end
            default: begin
                $display("Model fetched an unsupported opcode at 0x%08h", modelPc);
                abortRun();
            end
        endcase
        modelPc = nextPc;
    endtask

    task automatic handleTransfer(
        input logic [`DATA_W-1:0] addr,
        input logic               wr,
        input logic [`DATA_W-1:0] wdata
    );
        isaPkg::instrWordT w;
        if (!expectData) begin
            checkAddr(addr, modelPc);
            checkWriteFlag(wr, 1'b0);
            if (modelPc == LoopAddr) begin
                $display("Final loop fetched at 0x%08h after %0d cycles", modelPc, cycleCount);
                if (dut.uSva.failCount == 0) begin
                    $display("Result: PASSED");
                    $finish;
                end else begin
                    $display("A memory interface assertion failed during the run");
                    abortRun();
                end
            end else begin
                w = mem[wordIndex(modelPc)];
                executeModel(w);
            end
        end else begin
            checkAddr(addr, dataAddr);
            checkWriteFlag(wr, dataIsWrite);
            if (dataIsWrite) begin
                checkWData(wdata, dataWData);
                mem[wordIndex(addr)] = wdata;
            end else begin
                writeReg(loadDest, mem[wordIndex(addr)]);
            end
            expectData = 1'b0;
        end
    endtask

    initial begin
        buildProgram();
        for (int i = 0; i < `REG_N; i++) begin
            modelRegs[i] = '0;
        end
        modelPc     = `RESET_PC;
        expectData  = 1'b0;
        dataIsWrite = 1'b0;
        dataAddr    = '0;
        dataWData   = '0;
        loadDest    = '0;
    end

    ////////////////////////////////////////
    // Memory responder and timeout
    ////////////////////////////////////////

    // Each request waits one cycle plus a random 0 to 3 before memReady rises.
    always @(posedge clk) begin
        if (rstN) begin
            if (memValid && memReady) begin
                memReady <= 1'b0;
                waitDrawn = 1'b0;
                handleTransfer(memAddr, memWrite, memWData);
            end else if (memValid) begin
                if (!waitDrawn) begin
                    waitLeft = 2'(randBits(2));
                    waitDrawn = 1'b1;
                end
                if (waitLeft == 2'd0) begin
                    memReady <= 1'b1;
                    memRData <= mem[wordIndex(memAddr)];
                end else begin
                    waitLeft = waitLeft - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (dut.uSva.failCount != 0) begin
            $display("A memory interface assertion failed");
            abortRun();
        end else if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the final loop was not reached within %0d cycles", TimeoutCycles);
            abortRun();
        end
    end

endmodule

// File: mipsCore.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
ctrlIf.sv
regFile.sv
alu.sv
controller.sv
datapath.sv
mipsCore.sv
mipsCore_sva.sv
tbClock.sv
mipsCore_tb.sv
